//--- bench/decode_properties.sv
/* Handshake rules of decode_top, bound into every instance of it.
   All checks are off while rst_n_i is low, except the one on leaving reset */
module decode_properties
  import rv_pkg::*;
(
  input logic         clk,
  input logic         rst_n_i,
  input logic         jump_i,
  input logic         fetch_ready_o,
  input logic         id_valid_o,
  input logic         id_ready_i,
  input rv_pc_t       id_pc_o,
  input rv_op_sel_t   id_rs1_op_o,
  input rv_op_sel_t   id_rs2_op_o,
  input rv_funct3_t   id_f3_o,
  input logic         id_alt_o,
  input rv_word_t     id_imm_o,
  input rv_reg_addr_t id_rd_addr_o,
  input logic         id_we_rd_o,
  input rv_lsu_t      id_lsu_o,
  input logic         id_branch_o,
  input logic         id_jump_o,
  input logic         id_illegal_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // First edge out of reset still shows the reset state
  assert property (@(posedge clk) $rose(rst_n_i) |-> !id_valid_o)
    else begin
      fail_count++;
      $error("id_valid_o high right after reset");
    end

  // Operand data is left out since it follows writeback
  assert property (@(posedge clk) disable iff (!rst_n_i)
    id_valid_o && !id_ready_i && !jump_i |=>
      $stable({id_valid_o, id_pc_o, id_rs1_op_o, id_rs2_op_o, id_f3_o, id_alt_o,
               id_imm_o, id_rd_addr_o, id_we_rd_o, id_lsu_o, id_branch_o,
               id_jump_o, id_illegal_o}))
    else begin
      fail_count++;
      $error("decoded bundle changed while held");
    end

  assert property (@(posedge clk) disable iff (!rst_n_i) jump_i |-> !fetch_ready_o)
    else begin
      fail_count++;
      $error("fetch_ready_o high during a jump");
    end

  assert property (@(posedge clk) disable iff (!rst_n_i) id_illegal_o |-> !id_we_rd_o)
    else begin
      fail_count++;
      $error("illegal instruction writes a register");
    end

endmodule

bind decode_top decode_properties u_decode_properties (.*);

//--- bench/decode_tb.sv
/* Random instruction stream with random back-pressure, writeback and jumps.
   Jumps start after cycle 30 so the first-instruction latency is seen clean */
`include "rv_core_cfg.svh"

module decode_tb
  import rv_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int N_INSTR    = 2000;

  logic         clk;
  logic         rst_n_i;
  logic         fetch_valid_i;
  rv_word_t     fetch_instr_i;
  logic         fetch_ready_o;
  logic         jump_i;
  rv_pc_t       pc_jump_i;
  logic         wb_we_i;
  rv_reg_addr_t wb_rd_addr_i;
  rv_word_t     wb_rd_data_i;
  logic         id_valid_o;
  logic         id_ready_i;
  rv_pc_t       id_pc_o;
  rv_op_sel_t   id_rs1_op_o;
  rv_op_sel_t   id_rs2_op_o;
  rv_funct3_t   id_f3_o;
  logic         id_alt_o;
  rv_word_t     id_imm_o;
  rv_reg_addr_t id_rd_addr_o;
  logic         id_we_rd_o;
  rv_lsu_t      id_lsu_o;
  logic         id_branch_o;
  logic         id_jump_o;
  logic         id_illegal_o;
  rv_word_t     rs1_data_o;
  rv_word_t     rs2_data_o;

  // Reference model state
  rv_word_t     exp_q [$];
  rv_word_t     mregs [`RV_NUM_REGS];
  rv_pc_t       model_pc;
  logic [15:0]  lfsr;
  logic         fetch_taken;
  logic         seen_valid;
  int           cyc;
  int           first_fetch_cyc;
  int           n_out;
  int           val_errors;
  int           proto_errors;

  decode_top dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps x^16 + x^14 + x^13 + x^11 with one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Eleven of 16 picks give a legal opcode and the rest an unknown one
  function automatic rv_word_t make_instr();
    logic [3:0] pick;
    rv_word_t   ins;
    ins  = rand_bits(32);
    pick = 4'(rand_bits(4));
    case (pick)
      4'd0:    ins[6:0] = RV_OP_IMM;
      4'd1:    ins[6:0] = RV_LUI;
      4'd2:    ins[6:0] = RV_AUIPC;
      4'd3:    ins[6:0] = RV_OP;
      4'd4:    ins[6:0] = RV_JAL;
      4'd5:    ins[6:0] = RV_JALR;
      4'd6:    ins[6:0] = RV_BRANCH;
      4'd7:    ins[6:0] = RV_LOAD;
      4'd8:    ins[6:0] = RV_STORE;
      4'd9:    ins[6:0] = RV_MISC_MEM;
      4'd10:   ins[6:0] = RV_SYSTEM;
      4'd11:   ins[6:0] = 7'b0000000;
      4'd12:   ins[6:0] = 7'b1111111;
      4'd13:   ins[6:0] = 7'b1010011;
      default: ins[6:0] = 7'b0101011;
    endcase
    return ins;
  endfunction

  // Sign-extended immediate by instruction format
  function automatic rv_word_t ref_imm(input rv_word_t ins);
    case (ins[6:0])
      RV_OP_IMM, RV_JALR, RV_LOAD: return {{20{ins[31]}}, ins[31:20]};
      RV_STORE:                    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
      RV_BRANCH:  return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      RV_LUI, RV_AUIPC:            return {ins[31:12], 12'h000};
      RV_JAL:     return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      default:                     return '0;
    endcase
  endfunction

  // Register read as seen in this cycle where a write in flight wins
  function automatic rv_word_t reg_read(input rv_reg_addr_t a);
    if (a == '0) begin
      return '0;
    end
    if (wb_we_i && (wb_rd_addr_i == a)) begin
      return wb_rd_data_i;
    end
    return mregs[a];
  endfunction

  task automatic check_word(input string name, input rv_word_t got, input rv_word_t exp);
    if (got !== exp) begin
      val_errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_pc(input string name, input rv_pc_t got, input rv_pc_t exp);
    if (got !== exp) begin
      val_errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input rv_op_sel_t got, input rv_op_sel_t exp);
    if (got !== exp) begin
      val_errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_lsu(input string name, input rv_lsu_t got, input rv_lsu_t exp);
    if (got !== exp) begin
      val_errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  // Flags and small fields such as funct3 and rd
  task automatic check_ctrl(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      val_errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bundle(input rv_word_t ins, input rv_pc_t pc);
    rv_op_sel_t s1;
    rv_op_sel_t s2;
    rv_funct3_t f3;
    logic       alt;
    logic       we;
    rv_lsu_t    lsu;
    logic       br;
    logic       jp;
    logic       ill;
    s1  = REG_RF;
    s2  = IMM;
    f3  = ins[14:12];
    alt = 1'b0;
    we  = 1'b1;
    lsu = NO_LSU;
    br  = 1'b0;
    jp  = 1'b0;
    ill = 1'b0;
    case (ins[6:0])
      RV_OP_IMM: begin
        alt = (ins[14:12] == 3'b101) && ins[30];
      end
      RV_LUI: begin
        s1 = ZERO;
        f3 = '0;
      end
      RV_AUIPC: begin
        s1 = PC;
        f3 = '0;
      end
      RV_OP: begin
        s2  = REG_RF;
        alt = ins[30];
      end
      RV_JAL: begin
        s1 = PC;
        f3 = '0;
        jp = 1'b1;
      end
      RV_JALR: begin
        f3 = '0;
        jp = 1'b1;
      end
      RV_BRANCH: begin
        s2 = REG_RF;
        we = 1'b0;
        br = 1'b1;
      end
      RV_LOAD: begin
        lsu = LSU_LOAD;
      end
      RV_STORE: begin
        lsu = LSU_STORE;
        we  = 1'b0;
      end
      RV_MISC_MEM, RV_SYSTEM: begin
        s1 = ZERO;
        s2 = ZERO;
        f3 = '0;
        we = 1'b0;
      end
      default: begin
        we  = 1'b0;
        ill = 1'b1;
      end
    endcase
    check_pc("id_pc_o", id_pc_o, pc);
    check_sel("id_rs1_op_o", id_rs1_op_o, s1);
    check_sel("id_rs2_op_o", id_rs2_op_o, s2);
    check_ctrl("id_f3_o", 5'(id_f3_o), 5'(f3));
    check_ctrl("id_alt_o", 5'(id_alt_o), 5'(alt));
    check_word("id_imm_o", id_imm_o, ref_imm(ins));
    check_ctrl("id_rd_addr_o", id_rd_addr_o, ins[11:7]);
    check_ctrl("id_we_rd_o", 5'(id_we_rd_o), 5'(we));
    check_lsu("id_lsu_o", id_lsu_o, lsu);
    check_ctrl("id_branch_o", 5'(id_branch_o), 5'(br));
    check_ctrl("id_jump_o", 5'(id_jump_o), 5'(jp));
    check_ctrl("id_illegal_o", 5'(id_illegal_o), 5'(ill));
    check_word("rs1_data_o", rs1_data_o, reg_read(ins[19:15]));
    check_word("rs2_data_o", rs2_data_o, reg_read(ins[24:20]));
  endtask

  // Monitor samples pre-edge values and updates the model after the checks
  always @(posedge clk) begin
    if (rst_n_i) begin
      cyc++;
      if (jump_i) begin
        check_ctrl("fetch_ready_o", 5'(fetch_ready_o), 5'd0);
        exp_q.delete();
        model_pc = pc_jump_i;
      end else begin
        // Queue plus decode register hold RV_QUEUE_DEPTH + 1 when full
        check_ctrl("fetch_ready_o", 5'(fetch_ready_o),
                   5'(exp_q.size() <= `RV_QUEUE_DEPTH));
        if (id_valid_o && id_ready_i) begin
          if (exp_q.size() == 0) begin
            proto_errors++;
            $display("Output handshake with no instruction outstanding at cycle %0d", cyc);
          end else begin
            check_bundle(exp_q.pop_front(), model_pc);
            model_pc = model_pc + 32'd4;
            n_out++;
          end
        end
        if (fetch_valid_i && fetch_ready_o) begin
          exp_q.push_back(fetch_instr_i);
          fetch_taken = 1'b1;
          if (first_fetch_cyc < 0) begin
            first_fetch_cyc = cyc;
          end
        end
      end
      if (!seen_valid && id_valid_o) begin
        seen_valid = 1'b1;
        if (cyc - first_fetch_cyc != 2) begin
          proto_errors++;
          $display("First instruction took %0d edges instead of 2", cyc - first_fetch_cyc);
        end
      end
      if (wb_we_i && (wb_rd_addr_i != '0)) begin
        mregs[wb_rd_addr_i] = wb_rd_data_i;
      end
    end
  end

  initial begin
    #(N_INSTR * 20 * CLK_PERIOD);
    $display("Timeout, only %0d of %0d instructions came out", n_out, N_INSTR);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    fetch_valid_i   = 1'b0;
    fetch_instr_i   = '0;
    jump_i          = 1'b0;
    pc_jump_i       = '0;
    wb_we_i         = 1'b0;
    wb_rd_addr_i    = '0;
    wb_rd_data_i    = '0;
    id_ready_i      = 1'b0;
    lfsr            = 16'd55;
    model_pc        = `RV_PC_RESET;
    fetch_taken     = 1'b0;
    seen_valid      = 1'b0;
    cyc             = 0;
    first_fetch_cyc = -1;
    n_out           = 0;
    val_errors      = 0;
    proto_errors    = 0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      mregs[i] = '0;
    end
    repeat (10) @(negedge clk);
    rst_n_i = 1'b1;

    while (n_out < N_INSTR) begin
      @(negedge clk);
      // Execute side is held off during a jump
      if ((cyc > 30) && (rand_bits(6) == 0)) begin
        jump_i     = 1'b1;
        pc_jump_i  = {30'(rand_bits(30)), 2'b00};
        id_ready_i = 1'b0;
      end else begin
        jump_i     = 1'b0;
        id_ready_i = (rand_bits(2) != 0);
      end
      // Valid holds its instruction until the transfer
      if (fetch_taken || !fetch_valid_i) begin
        fetch_taken   = 1'b0;
        fetch_valid_i = (rand_bits(3) != 0);
        fetch_instr_i = make_instr();
      end
      wb_we_i      = 1'(rand_bits(1));
      wb_rd_addr_i = rv_reg_addr_t'(rand_bits(5));
      wb_rd_data_i = rand_bits(32);
    end

    @(negedge clk);
    $display("Checked %0d instructions: %0d value errors, %0d other errors, %0d assertion errors",
             n_out, val_errors, proto_errors, dut.u_decode_properties.fail_count);
    if ((val_errors == 0) && (proto_errors == 0) &&
        (dut.u_decode_properties.fail_count == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_queue.sv
rtl/register_file.sv
rtl/decode.sv
rtl/decode_top.sv
bench/decode_properties.sv
bench/decode_tb.sv

//--- rtl/decode.sv
/* Decode stage with a single output register. Operand data is read with the held
   source addresses, so it follows writeback while the bundle waits on id_ready_i */
`include "rv_core_cfg.svh"

module decode
  import rv_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         jump_i,
  input  rv_pc_t       pc_jump_i,
  input  logic         in_valid_i,
  input  rv_word_t     in_instr_i,
  output logic         in_ready_o,
  input  logic         wb_we_i,
  input  rv_reg_addr_t wb_rd_addr_i,
  input  rv_word_t     wb_rd_data_i,
  output logic         id_valid_o,
  input  logic         id_ready_i,
  output rv_pc_t       id_pc_o,
  output rv_op_sel_t   id_rs1_op_o,
  output rv_op_sel_t   id_rs2_op_o,
  output rv_funct3_t   id_f3_o,
  output logic         id_alt_o,
  output rv_word_t     id_imm_o,
  output rv_reg_addr_t id_rd_addr_o,
  output logic         id_we_rd_o,
  output rv_lsu_t      id_lsu_o,
  output logic         id_branch_o,
  output logic         id_jump_o,
  output logic         id_illegal_o,
  output rv_word_t     rs1_data_o,
  output rv_word_t     rs2_data_o
);
  rv_opcode_t   opcode;
  rv_funct3_t   funct3;
  logic         accept;
  rv_pc_t       pc_next_q;
  rv_reg_addr_t rs1_addr_q;
  rv_reg_addr_t rs2_addr_q;

  rv_op_sel_t   dec_rs1_op;
  rv_op_sel_t   dec_rs2_op;
  rv_funct3_t   dec_f3;
  logic         dec_alt;
  logic         dec_we_rd;
  rv_lsu_t      dec_lsu;
  logic         dec_branch;
  logic         dec_jump;
  logic         dec_illegal;

  assign opcode = in_instr_i[6:0];
  assign funct3 = in_instr_i[14:12];

  // Register empty, or its bundle leaves this cycle
  assign in_ready_o = !jump_i && (!id_valid_o || id_ready_i);
  assign accept     = in_valid_i && in_ready_o;

  always_comb begin
    dec_rs1_op  = REG_RF;
    dec_rs2_op  = IMM;
    dec_f3      = funct3;
    dec_alt     = 1'b0;
    dec_we_rd   = 1'b0;
    dec_lsu     = NO_LSU;
    dec_branch  = 1'b0;
    dec_jump    = 1'b0;
    dec_illegal = 1'b0;
    case (opcode)
      RV_OP_IMM: begin
        // Bit 30 only selects SRAI over SRLI
        dec_alt   = (funct3 == 3'b101) && in_instr_i[30];
        dec_we_rd = 1'b1;
      end
      RV_LUI: begin
        dec_rs1_op = ZERO;
        dec_f3     = 3'b000;
        dec_we_rd  = 1'b1;
      end
      RV_AUIPC: begin
        dec_rs1_op = PC;
        dec_f3     = 3'b000;
        dec_we_rd  = 1'b1;
      end
      RV_OP: begin
        dec_rs2_op = REG_RF;
        dec_alt    = in_instr_i[30];
        dec_we_rd  = 1'b1;
      end
      RV_JAL: begin
        dec_rs1_op = PC;
        dec_f3     = 3'b000;
        dec_we_rd  = 1'b1;
        dec_jump   = 1'b1;
      end
      RV_JALR: begin
        dec_f3    = 3'b000;
        dec_we_rd = 1'b1;
        dec_jump  = 1'b1;
      end
      RV_BRANCH: begin
        dec_rs2_op = REG_RF;
        dec_branch = 1'b1;
      end
      // funct3 carries the access width for loads and stores
      RV_LOAD: begin
        dec_lsu   = LSU_LOAD;
        dec_we_rd = 1'b1;
      end
      RV_STORE: begin
        dec_lsu = LSU_STORE;
      end
      RV_MISC_MEM, RV_SYSTEM: begin
        dec_rs1_op = ZERO;
        dec_rs2_op = ZERO;
        dec_f3     = 3'b000;
      end
      default: begin
        dec_illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_valid_o   <= 1'b0;
      pc_next_q    <= `RV_PC_RESET;
      id_we_rd_o   <= 1'b0;
      id_lsu_o     <= NO_LSU;
      id_branch_o  <= 1'b0;
      id_jump_o    <= 1'b0;
      id_illegal_o <= 1'b0;
    end else if (jump_i) begin
      id_valid_o <= 1'b0;
      pc_next_q  <= pc_jump_i;
    end else if (accept) begin
      id_valid_o   <= 1'b1;
      pc_next_q    <= pc_next_q + 32'd4;
      id_we_rd_o   <= dec_we_rd;
      id_lsu_o     <= dec_lsu;
      id_branch_o  <= dec_branch;
      id_jump_o    <= dec_jump;
      id_illegal_o <= dec_illegal;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  // Rest of the bundle, loaded with the flags above
  always_ff @(posedge clk) begin
    if (accept) begin
      id_pc_o      <= pc_next_q;
      id_rs1_op_o  <= dec_rs1_op;
      id_rs2_op_o  <= dec_rs2_op;
      id_f3_o      <= dec_f3;
      id_alt_o     <= dec_alt;
      id_imm_o     <= rv_imm_gen(in_instr_i);
      id_rd_addr_o <= in_instr_i[11:7];
      rs1_addr_q   <= in_instr_i[19:15];
      rs2_addr_q   <= in_instr_i[24:20];
    end
  end

  register_file u_register_file (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rs1_addr_i(rs1_addr_q),
    .rs2_addr_i(rs2_addr_q),
    .we_i      (wb_we_i),
    .rd_addr_i (wb_rd_addr_i),
    .rd_data_i (wb_rd_data_i),
    .rs1_data_o(rs1_data_o),
    .rs2_data_o(rs2_data_o)
  );

endmodule

//--- rtl/decode_top.sv
/* Fetch queue in front of the decode stage. Two edges from fetch handshake to
   id_valid_o without back-pressure, and jump_i flushes both stages */
module decode_top
  import rv_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         fetch_valid_i,
  input  rv_word_t     fetch_instr_i,
  output logic         fetch_ready_o,
  input  logic         jump_i,
  input  rv_pc_t       pc_jump_i,
  input  logic         wb_we_i,
  input  rv_reg_addr_t wb_rd_addr_i,
  input  rv_word_t     wb_rd_data_i,
  output logic         id_valid_o,
  input  logic         id_ready_i,
  output rv_pc_t       id_pc_o,
  output rv_op_sel_t   id_rs1_op_o,
  output rv_op_sel_t   id_rs2_op_o,
  output rv_funct3_t   id_f3_o,
  output logic         id_alt_o,
  output rv_word_t     id_imm_o,
  output rv_reg_addr_t id_rd_addr_o,
  output logic         id_we_rd_o,
  output rv_lsu_t      id_lsu_o,
  output logic         id_branch_o,
  output logic         id_jump_o,
  output logic         id_illegal_o,
  output rv_word_t     rs1_data_o,
  output rv_word_t     rs2_data_o
);
  logic     q_valid;
  rv_word_t q_instr;
  logic     q_ready;

  fetch_queue u_fetch_queue (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .flush_i    (jump_i),
    .in_valid_i (fetch_valid_i),
    .in_instr_i (fetch_instr_i),
    .in_ready_o (fetch_ready_o),
    .out_valid_o(q_valid),
    .out_instr_o(q_instr),
    .out_ready_i(q_ready)
  );

  decode u_decode (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .jump_i      (jump_i),
    .pc_jump_i   (pc_jump_i),
    .in_valid_i  (q_valid),
    .in_instr_i  (q_instr),
    .in_ready_o  (q_ready),
    .wb_we_i     (wb_we_i),
    .wb_rd_addr_i(wb_rd_addr_i),
    .wb_rd_data_i(wb_rd_data_i),
    .id_valid_o  (id_valid_o),
    .id_ready_i  (id_ready_i),
    .id_pc_o     (id_pc_o),
    .id_rs1_op_o (id_rs1_op_o),
    .id_rs2_op_o (id_rs2_op_o),
    .id_f3_o     (id_f3_o),
    .id_alt_o    (id_alt_o),
    .id_imm_o    (id_imm_o),
    .id_rd_addr_o(id_rd_addr_o),
    .id_we_rd_o  (id_we_rd_o),
    .id_lsu_o    (id_lsu_o),
    .id_branch_o (id_branch_o),
    .id_jump_o   (id_jump_o),
    .id_illegal_o(id_illegal_o),
    .rs1_data_o  (rs1_data_o),
    .rs2_data_o  (rs2_data_o)
  );

endmodule

//--- rtl/fetch_queue.sv
/* Instruction FIFO without fall-through, so a write shows on the output one edge later.
   A flush drops every entry and refuses new ones in the same cycle */
`include "rv_core_cfg.svh"

module fetch_queue
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  input  rv_word_t in_instr_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output rv_word_t out_instr_o,
  input  logic     out_ready_i
);
  localparam int DEPTH = `RV_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  rv_word_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  assign in_ready_o  = (count != CNT_W'(DEPTH)) && !flush_i;
  assign out_valid_o = (count != '0);
  assign out_instr_o = mem[rd_ptr];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Storage only
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_instr_i;
    end
  end

endmodule

//--- rtl/register_file.sv
/* Integer register file with two combinational reads. A write in the same cycle
   is forwarded to the readers, and x0 reads zero whatever was written */
`include "rv_core_cfg.svh"

module register_file
  import rv_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  rv_reg_addr_t rs1_addr_i,
  input  rv_reg_addr_t rs2_addr_i,
  input  logic         we_i,
  input  rv_reg_addr_t rd_addr_i,
  input  rv_word_t     rd_data_i,
  output rv_word_t     rs1_data_o,
  output rv_word_t     rs2_data_o
);
  rv_word_t regs [`RV_NUM_REGS];
  logic     wr_en;

  // x0 is never written
  assign wr_en = we_i && (rd_addr_i != '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // Bypass the write port so a read sees the value being written
  assign rs1_data_o = (rs1_addr_i == '0)                    ? '0 :
                      (wr_en && (rd_addr_i == rs1_addr_i)) ? rd_data_i :
                                                             regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0)                    ? '0 :
                      (wr_en && (rd_addr_i == rs2_addr_i)) ? rd_data_i :
                                                             regs[rs2_addr_i];

endmodule

//--- rtl/rv_core_cfg.svh
/* Core configuration. The fetch queue needs RV_QUEUE_DEPTH of at least 2,
   and RV_NUM_REGS must stay 32 to match the 5-bit register index */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Address of the first instruction after reset
`define RV_PC_RESET 32'h0000_0000

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// Entries in the fetch queue
`define RV_QUEUE_DEPTH 2

`endif

//--- rtl/rv_pkg.sv
/* Shared RV32I types and opcodes. Only the base integer opcodes are known here,
   anything else is left to the decoder to flag as illegal */
package rv_pkg;

  typedef logic [31:0] rv_word_t;
  typedef logic [31:0] rv_pc_t;
  typedef logic [4:0]  rv_reg_addr_t;
  typedef logic [2:0]  rv_funct3_t;
  typedef logic [6:0]  rv_opcode_t;

  // Operand source for the execute stage
  typedef enum logic [1:0] {
    REG_RF,
    IMM,
    PC,
    ZERO
  } rv_op_sel_t;

  typedef enum logic [1:0] {
    NO_LSU,
    LSU_LOAD,
    LSU_STORE
  } rv_lsu_t;

  // Major opcodes, instruction bits 6:0
  localparam rv_opcode_t RV_OP_IMM   = 7'b0010011;
  localparam rv_opcode_t RV_LUI      = 7'b0110111;
  localparam rv_opcode_t RV_AUIPC    = 7'b0010111;
  localparam rv_opcode_t RV_OP       = 7'b0110011;
  localparam rv_opcode_t RV_JAL      = 7'b1101111;
  localparam rv_opcode_t RV_JALR     = 7'b1100111;
  localparam rv_opcode_t RV_BRANCH   = 7'b1100011;
  localparam rv_opcode_t RV_LOAD     = 7'b0000011;
  localparam rv_opcode_t RV_STORE    = 7'b0100011;
  localparam rv_opcode_t RV_MISC_MEM = 7'b0001111;
  localparam rv_opcode_t RV_SYSTEM   = 7'b1110011;

  // Immediate format follows from the opcode, zero when there is none
  function automatic rv_word_t rv_imm_gen(input rv_word_t instr);
    rv_word_t imm;
    imm = '0;
    case (rv_opcode_t'(instr[6:0]))
      RV_OP_IMM, RV_JALR, RV_LOAD: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      RV_STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      RV_BRANCH: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      RV_LUI, RV_AUIPC: begin
        imm = {instr[31:12], 12'b0};
      end
      RV_JAL: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
    return imm;
  endfunction

endpackage
